//--- src/uart_reg_pkg.sv
// UART register map package
// Bus field types, register byte offsets and the bit layout of the
// control and status registers

package uart_reg_pkg;

  ////////////////////////////////////////////////////////////
  // Peripheral bus types
  ////////////////////////////////////////////////////////////

  // Word address on the peripheral bus
  typedef logic [13:0] per_addr_t;
  // Bus data word
  typedef logic [15:0] per_data_t;
  // Byte write enables, bit 1 for the high byte
  typedef logic [1:0]  per_we_t;

  // One 8-bit register
  typedef logic [7:0]  reg_byte_t;
  // Byte offset inside the 8-byte block
  typedef logic [2:0]  reg_off_t;

  ////////////////////////////////////////////////////////////
  // Register byte offsets
  ////////////////////////////////////////////////////////////

  localparam reg_off_t CTRL_OFF    = 3'd0;
  localparam reg_off_t STATUS_OFF  = 3'd1;
  localparam reg_off_t BAUD_LO_OFF = 3'd2;
  localparam reg_off_t BAUD_HI_OFF = 3'd3;
  localparam reg_off_t DATA_TX_OFF = 3'd4;
  localparam reg_off_t DATA_RX_OFF = 3'd5;

  // Control bits
  localparam int unsigned CTRL_IEN_TX       = 6;
  localparam int unsigned CTRL_IEN_RX_OVFLW = 5;
  localparam int unsigned CTRL_IEN_RX       = 4;
  localparam int unsigned CTRL_EN           = 0;
  // Only these control bits hold a value
  localparam reg_byte_t   CTRL_WR_MASK      = 8'h71;

  // Status bits, bits 7 and 1 always read 0
  localparam int unsigned STAT_TX_PND       = 6;
  localparam int unsigned STAT_RX_OVFLW_PND = 5;
  localparam int unsigned STAT_RX_PND       = 4;
  localparam int unsigned STAT_TX_FULL      = 3;
  localparam int unsigned STAT_TX_BUSY      = 2;
  localparam int unsigned STAT_RX_BUSY      = 0;

endpackage

//--- src/uart_line_pkg.sv
// UART serial line package
// Types and frame constants shared by the transmit and receive engines

package uart_line_pkg;

  ////////////////////////////////////////////////////////////
  // Line types
  ////////////////////////////////////////////////////////////

  // Baud divider, one bit lasts divider+1 clock cycles
  typedef logic [15:0] baud_t;

  // Position inside a frame, 0 when idle
  typedef logic [3:0]  bit_idx_t;

  // One character
  typedef logic [7:0]  data_byte_t;

  ////////////////////////////////////////////////////////////
  // Frame constants
  ////////////////////////////////////////////////////////////

  // Receive frame complete after start and 8 data samples
  localparam bit_idx_t RX_LAST_BIT = 4'd10;

  // Transmit frame complete once the stop bit has run a full bit time
  localparam bit_idx_t TX_LAST_BIT = 4'd11;

endpackage

//--- src/uart_regs.sv
// UART register block
// Decodes the peripheral bus, holds control, baud and data registers,
// keeps the three pending flags and drives both interrupt lines

`timescale 1ns/1ps

module uart_regs
  import uart_reg_pkg::*;
  import uart_line_pkg::*;
#(
  parameter logic [14:0] BASE_ADDR = 15'h0080
) (
  input  logic       mclk,
  input  logic       puc_rst,
  // Peripheral bus
  input  logic       per_en,
  input  per_addr_t  per_addr,
  input  per_data_t  per_din,
  input  per_we_t    per_we,
  output per_data_t  per_dout,
  // Transmit engine
  input  logic       tx_done,
  input  logic       tx_busy,
  input  logic       tx_full,
  output logic       tx_load,
  output data_byte_t tx_data,
  // Receive engine
  input  logic       rx_done,
  input  data_byte_t rx_byte,
  input  logic       rx_busy,
  // Shared line setup
  output logic       ctrl_en,
  output baud_t      baud,
  // Interrupts
  output logic       irq_uart_rx,
  output logic       irq_uart_tx
);

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  logic                 reg_sel;
  logic                 reg_read;
  logic [7:0]           reg_wr;
  reg_byte_t [7:0]      rd_bytes;

  reg_byte_t            ctrl;
  reg_byte_t            status;
  reg_byte_t            baud_lo;
  reg_byte_t            baud_hi;
  reg_byte_t            data_tx;
  reg_byte_t            data_rx;
  reg_byte_t            status_nxt;

  // Pending flags, index 2 tx, 1 rx overflow, 0 rx
  logic [2:0]           pnd;
  logic [2:0]           pnd_set;
  logic [2:0]           pnd_clr;

  // Byte lane of a register, odd offsets sit in the high byte
  function automatic reg_byte_t lane(input per_data_t d, input reg_off_t off);
    return off[0] ? d[15:8] : d[7:0];
  endfunction

  // Block hit when the upper word address matches the base
  assign reg_sel  = per_en & (per_addr[13:2] == BASE_ADDR[14:3]);
  assign reg_read = reg_sel & ~|per_we;

  // Per-offset byte write strobes
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      reg_wr[i] = reg_sel & (per_addr[1:0] == 2'(i >> 1)) & per_we[i % 2];
    end
  end

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ctrl    <= '0;
      baud_lo <= '0;
      baud_hi <= '0;
      data_tx <= '0;
    end else begin
      // Unused control bits stay 0
      if (reg_wr[CTRL_OFF]) ctrl <= lane(per_din, CTRL_OFF) & CTRL_WR_MASK;
      if (reg_wr[BAUD_LO_OFF]) baud_lo <= lane(per_din, BAUD_LO_OFF);
      if (reg_wr[BAUD_HI_OFF]) baud_hi <= lane(per_din, BAUD_HI_OFF);
      if (reg_wr[DATA_TX_OFF]) data_tx <= lane(per_din, DATA_TX_OFF);
    end
  end

  // Received character, latched on frame completion
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      data_rx <= '0;
    end else if (rx_done) begin
      data_rx <= rx_byte;
    end
  end

  assign ctrl_en = ctrl[CTRL_EN];
  assign baud    = {baud_hi, baud_lo};
  // Load strobe straight from the data write
  assign tx_load = reg_wr[DATA_TX_OFF];
  assign tx_data = data_tx;

  ////////////////////////////////////////////////////////////
  // Pending flags
  ////////////////////////////////////////////////////////////

  // Write 1 to clear
  assign status_nxt = lane(per_din, STATUS_OFF);
  assign pnd_clr    = {status_nxt[STAT_TX_PND], status_nxt[STAT_RX_OVFLW_PND],
                       status_nxt[STAT_RX_PND]} & {3{reg_wr[STATUS_OFF]}};
  // Overflow when a byte lands on an unread one
  assign pnd_set    = {tx_done, rx_done & pnd[0], rx_done};

  // Set wins over a clear in the same cycle
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      pnd <= '0;
    end else begin
      pnd <= (pnd & ~pnd_clr) | pnd_set;
    end
  end

  ////////////////////////////////////////////////////////////
  // Status byte and read data
  ////////////////////////////////////////////////////////////

  always_comb begin
    status                    = '0;
    status[STAT_TX_PND]       = pnd[2];
    status[STAT_RX_OVFLW_PND] = pnd[1];
    status[STAT_RX_PND]       = pnd[0];
    status[STAT_TX_FULL]      = tx_full;
    status[STAT_TX_BUSY]      = tx_busy;
    status[STAT_RX_BUSY]      = rx_busy;
  end

  // Register image by byte offset, spare offsets read 0
  always_comb begin
    rd_bytes              = '0;
    rd_bytes[CTRL_OFF]    = ctrl;
    rd_bytes[STATUS_OFF]  = status;
    rd_bytes[BAUD_LO_OFF] = baud_lo;
    rd_bytes[BAUD_HI_OFF] = baud_hi;
    rd_bytes[DATA_TX_OFF] = data_tx;
    rd_bytes[DATA_RX_OFF] = data_rx;
  end

  // Zero unless this block is read
  assign per_dout = reg_read ? {rd_bytes[{per_addr[1:0], 1'b1}],
                                rd_bytes[{per_addr[1:0], 1'b0}]} : '0;

  ////////////////////////////////////////////////////////////
  // Interrupts
  ////////////////////////////////////////////////////////////

  assign irq_uart_rx = (pnd[0] & ctrl[CTRL_IEN_RX]) | (pnd[1] & ctrl[CTRL_IEN_RX_OVFLW]);
  assign irq_uart_tx = pnd[2] & ctrl[CTRL_IEN_TX];

endmodule

//--- src/uart_rx_filter.sv
// UART receive line conditioner
// Two-flop synchronizer, three-sample majority vote and falling-edge flag

`timescale 1ns/1ps

module uart_rx_filter (
  input  logic mclk,
  input  logic puc_rst,
  input  logic uart_rxd,
  output logic rxd_s,
  output logic rxd_fe
);

  logic [1:0] rxd_sync;
  logic [1:0] rxd_buf;
  logic       rxd_maj;
  logic       rxd_maj_nxt;

  // Synchronizer, idle line is high
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_sync <= 2'b11;
    end else begin
      rxd_sync <= {rxd_sync[0], uart_rxd};
    end
  end

  // Last two synchronized samples
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_buf <= 2'b11;
    end else begin
      rxd_buf <= {rxd_buf[0], rxd_sync[1]};
    end
  end

  // Two of three, a single-cycle glitch never wins
  assign rxd_maj_nxt = (rxd_sync[1] & rxd_buf[0]) | (rxd_sync[1] & rxd_buf[1]) |
                       (rxd_buf[0] & rxd_buf[1]);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_maj <= 1'b1;
    end else begin
      rxd_maj <= rxd_maj_nxt;
    end
  end

  assign rxd_s  = rxd_maj;
  // High one cycle ahead of the filtered drop
  assign rxd_fe = rxd_maj & ~rxd_maj_nxt;

endmodule

//--- src/uart_rx.sv
// UART receive engine
// Samples the filtered line at mid-bit and assembles one character per frame

`timescale 1ns/1ps

module uart_rx
  import uart_line_pkg::*;
(
  input  logic       mclk,
  input  logic       puc_rst,
  input  logic       ctrl_en,
  input  baud_t      baud,
  input  logic       rxd_s,
  input  logic       rxd_fe,
  output logic       rx_done,
  output data_byte_t rx_byte,
  output logic       rx_busy
);

  bit_idx_t   rx_bit;
  baud_t      rx_cnt;
  data_byte_t rx_buf;
  logic       rx_start;
  logic       rx_bit_inc;
  logic       rx_last;

  // Start on a falling edge while idle
  assign rx_start   = (rx_bit == '0) & rxd_fe;
  // Bit step when the baud counter runs out
  assign rx_bit_inc = (rx_bit != '0) & (rx_cnt == '0);
  assign rx_last    = (rx_bit == RX_LAST_BIT);

  ////////////////////////////////////////////////////////////
  // Bit and baud counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rx_bit <= '0;
    end else if (~ctrl_en) begin
      rx_bit <= '0;
    end else if (rx_start) begin
      rx_bit <= bit_idx_t'(1);
    end else if (rx_last) begin
      rx_bit <= '0;
    end else if (rx_bit_inc) begin
      rx_bit <= rx_bit + bit_idx_t'(1);
    end
  end

  // Half period first, so samples land mid-bit
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rx_cnt <= '0;
    end else if (~ctrl_en) begin
      rx_cnt <= '0;
    end else if (rx_start) begin
      rx_cnt <= {1'b0, baud[15:1]};
    end else if (rx_bit_inc) begin
      rx_cnt <= baud;
    end else if (rx_cnt != '0) begin
      rx_cnt <= rx_cnt - baud_t'(1);
    end
  end

  // Shift in LSB first, the start bit drops out the bottom
  always_ff @(posedge mclk) begin
    if (rx_bit_inc) begin
      rx_buf <= {rxd_s, rx_buf[7:1]};
    end
  end

  assign rx_done = rx_last & ctrl_en;
  assign rx_byte = rx_buf;
  assign rx_busy = (rx_bit != '0);

endmodule

//--- src/uart_tx.sv
// UART transmit engine
// One-byte holding trigger, frame bit and baud counters, and the
// shift register that drives TXD

`timescale 1ns/1ps

module uart_tx
  import uart_line_pkg::*;
(
  input  logic       mclk,
  input  logic       puc_rst,
  input  logic       ctrl_en,
  input  baud_t      baud,
  input  logic       tx_load,
  input  data_byte_t tx_data,
  output logic       tx_done,
  output logic       tx_busy,
  output logic       tx_full,
  output logic       uart_txd
);

  logic       tx_trig;
  bit_idx_t   tx_bit;
  baud_t      tx_cnt;
  logic [8:0] tx_buf;
  logic       tx_start;
  logic       tx_bit_inc;
  logic       tx_last;
  logic       tx_run;

  assign tx_run     = (tx_bit != '0);
  // Pending byte goes out once the engine is idle
  assign tx_start   = ~tx_run & tx_trig;
  assign tx_bit_inc = tx_run & (tx_cnt == '0);
  assign tx_last    = (tx_bit == TX_LAST_BIT);

  ////////////////////////////////////////////////////////////
  // Transmit trigger
  ////////////////////////////////////////////////////////////

  // A new load while pending just replaces the byte
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_trig <= 1'b0;
    end else if (~ctrl_en) begin
      tx_trig <= 1'b0;
    end else if (tx_load) begin
      tx_trig <= 1'b1;
    end else if (tx_start) begin
      tx_trig <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bit and baud counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_bit <= '0;
    end else if (~ctrl_en) begin
      tx_bit <= '0;
    end else if (tx_start) begin
      tx_bit <= bit_idx_t'(1);
    end else if (tx_last) begin
      tx_bit <= '0;
    end else if (tx_bit_inc) begin
      tx_bit <= tx_bit + bit_idx_t'(1);
    end
  end

  // Every bit lasts baud+1 cycles
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_cnt <= '0;
    end else if (~ctrl_en) begin
      tx_cnt <= '0;
    end else if (tx_start | tx_bit_inc) begin
      tx_cnt <= baud;
    end else if (tx_cnt != '0) begin
      tx_cnt <= tx_cnt - baud_t'(1);
    end
  end

  // Start bit at the bottom, ones shift in behind as stop and idle
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_buf <= '1;
    end else if (~ctrl_en) begin
      tx_buf <= '1;
    end else if (tx_start) begin
      tx_buf <= {tx_data, 1'b0};
    end else if (tx_bit_inc) begin
      tx_buf <= {1'b1, tx_buf[8:1]};
    end
  end

  assign uart_txd = tx_buf[0];
  assign tx_done  = tx_last & ctrl_en;
  assign tx_busy  = tx_run | tx_trig;
  // Frame on the line and another byte waiting
  assign tx_full  = tx_run & tx_trig;

endmodule

//--- src/msp430_uart.sv
// Serial port peripheral, top level
// Connects the register block to the receive filter and both line engines

`timescale 1ns/1ps

module msp430_uart
  import uart_reg_pkg::*;
  import uart_line_pkg::*;
#(
  parameter logic [14:0] BASE_ADDR = 15'h0080
) (
  input  logic      mclk,
  input  logic      puc_rst,
  input  logic      per_en,
  input  per_addr_t per_addr,
  input  per_data_t per_din,
  input  per_we_t   per_we,
  input  logic      uart_rxd,
  output per_data_t per_dout,
  output logic      irq_uart_rx,
  output logic      irq_uart_tx,
  output logic      uart_txd
);

  // Line setup from the registers
  logic       ctrl_en;
  baud_t      baud;
  // Transmit path
  logic       tx_load;
  data_byte_t tx_data;
  logic       tx_done;
  logic       tx_busy;
  logic       tx_full;
  // Receive path
  logic       rxd_s;
  logic       rxd_fe;
  logic       rx_done;
  data_byte_t rx_byte;
  logic       rx_busy;

  uart_regs #(
    .BASE_ADDR (BASE_ADDR)
  ) i_uart_regs (
    .mclk, .puc_rst,
    .per_en, .per_addr, .per_din, .per_we, .per_dout,
    .tx_done, .tx_busy, .tx_full, .tx_load, .tx_data,
    .rx_done, .rx_byte, .rx_busy,
    .ctrl_en, .baud,
    .irq_uart_rx, .irq_uart_tx
  );

  uart_rx_filter i_uart_rx_filter (
    .mclk, .puc_rst, .uart_rxd, .rxd_s, .rxd_fe
  );

  uart_rx i_uart_rx (
    .mclk, .puc_rst, .ctrl_en, .baud, .rxd_s, .rxd_fe,
    .rx_done, .rx_byte, .rx_busy
  );

  uart_tx i_uart_tx (
    .mclk, .puc_rst, .ctrl_en, .baud, .tx_load, .tx_data,
    .tx_done, .tx_busy, .tx_full, .uart_txd
  );

endmodule

//--- verification/msp430_uart_properties.sv
// Serial port checks bound into the top level
// Idle line level, interrupt gating by the enables, and quiet read data

`timescale 1ns/1ps

module msp430_uart_properties
  import uart_reg_pkg::*;
#(
  parameter logic [14:0] BASE_ADDR = 15'h0080
) (
  input logic      mclk,
  input logic      puc_rst,
  input logic      per_en,
  input per_addr_t per_addr,
  input per_data_t per_din,
  input per_we_t   per_we,
  input per_data_t per_dout,
  input logic      tx_busy,
  input logic      uart_txd,
  input logic      irq_uart_rx,
  input logic      irq_uart_tx
);

  // Interrupt enables seen on the bus, tx, rx overflow, rx
  logic [2:0] ien;
  logic       ctrl_wr;

  // CTRL is the low byte of the first word
  assign ctrl_wr = per_en & per_we[0] & (per_addr == BASE_ADDR[14:1]);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ien <= '0;
    end else if (ctrl_wr) begin
      ien <= {per_din[CTRL_IEN_TX], per_din[CTRL_IEN_RX_OVFLW], per_din[CTRL_IEN_RX]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////

  // Line rests high with no frame running or pending
  assert property (@(posedge mclk) disable iff (puc_rst) !tx_busy |-> uart_txd)
    else $error("TXD low while the transmit engine is idle");

  // Masked flags never reach the interrupt lines
  assert property (@(posedge mclk) disable iff (puc_rst)
                   (ien == 3'b000) |-> !(irq_uart_rx || irq_uart_tx))
    else $error("Interrupt raised with all enables cleared");

  // Bus data is quiet outside an access
  assert property (@(posedge mclk) disable iff (puc_rst) !per_en |-> (per_dout == '0))
    else $error("Read data driven without an access");

endmodule

bind msp430_uart msp430_uart_properties #(
  .BASE_ADDR (BASE_ADDR)
) i_msp430_uart_properties (
  .mclk        (mclk),
  .puc_rst     (puc_rst),
  .per_en      (per_en),
  .per_addr    (per_addr),
  .per_din     (per_din),
  .per_we      (per_we),
  .per_dout    (per_dout),
  .tx_busy     (tx_busy),
  .uart_txd    (uart_txd),
  .irq_uart_rx (irq_uart_rx),
  .irq_uart_tx (irq_uart_tx)
);

//--- verification/msp430_uart_tb.sv
// Serial port testbench
// Directed register, transmit, receive, overflow and disable tests

`timescale 1ns/1ps

module msp430_uart_tb
  import uart_reg_pkg::*;
();

  localparam logic [14:0] BASE_ADDR  = 15'h0080;
  localparam per_addr_t   BASE_WORD  = BASE_ADDR[14:1];
  localparam int          CLK_PERIOD = 4;
  localparam int          TEST_BAUD  = 7;
  localparam int          BIT_CYCLES = TEST_BAUD + 1;
  // Start, 8 data, stop and the closing bit time
  localparam int          FRAME_CYCLES    = 11 * BIT_CYCLES;
  localparam int          WAIT_LIMIT      = 2 * FRAME_CYCLES;
  localparam int          WATCHDOG_CYCLES = 12 * FRAME_CYCLES + 1000;
  // Outputs that the wait task can poll
  localparam int          SIG_TXD    = 0;
  localparam int          SIG_IRQ_TX = 1;
  localparam int          SIG_IRQ_RX = 2;

  logic        mclk;
  logic        puc_rst;
  logic        per_en;
  per_addr_t   per_addr;
  per_data_t   per_din;
  per_we_t     per_we;
  per_data_t   per_dout;
  logic        uart_rxd;
  logic        irq_uart_rx;
  logic        irq_uart_tx;
  logic        uart_txd;
  logic [31:0] lfsr_state;

  msp430_uart #(
    .BASE_ADDR (BASE_ADDR)
  ) i_msp430_uart (
    .mclk (mclk), .puc_rst (puc_rst), .per_en (per_en), .per_addr (per_addr),
    .per_din (per_din), .per_we (per_we), .uart_rxd (uart_rxd), .per_dout (per_dout),
    .irq_uart_rx (irq_uart_rx), .irq_uart_tx (irq_uart_tx), .uart_txd (uart_txd)
  );

  always #(CLK_PERIOD / 2) mclk = ~mclk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic reg_byte_t random_byte();
    reg_byte_t b;
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr_step();
    end
    return b;
  endfunction

  // Single-cycle bus write
  task automatic bus_write(input per_addr_t addr, input per_we_t we, input per_data_t din);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_addr <= addr;
    per_we   <= we;
    per_din  <= din;
    @(posedge mclk);
    per_en <= 1'b0;
    per_we <= '0;
  endtask

  // Read data sampled mid-cycle while the access is up
  task automatic bus_read(input per_addr_t addr, output per_data_t dout);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_addr <= addr;
    per_we   <= '0;
    @(negedge mclk);
    dout = per_dout;
    @(posedge mclk);
    per_en <= 1'b0;
  endtask

  // Odd offsets travel in the high byte lane
  task automatic reg_write(input reg_off_t off, input reg_byte_t val);
    per_addr_t addr;
    addr = BASE_WORD + per_addr_t'(off >> 1);
    if (off[0]) begin
      bus_write(addr, 2'b10, {val, 8'h00});
    end else begin
      bus_write(addr, 2'b01, {8'h00, val});
    end
  endtask

  task automatic check_reg(input string name, input reg_off_t off, input reg_byte_t expected);
    per_data_t word;
    bus_read(BASE_WORD + per_addr_t'(off >> 1), word);
    check_equal(name, {8'h00, expected}, {8'h00, off[0] ? word[15:8] : word[7:0]});
  endtask

  // Bounded poll of an output at each falling edge
  task automatic wait_level(input int sel, input logic level, input string what);
    int   cycles;
    logic v;
    cycles = 0;
    v      = ~level;
    while (v !== level) begin
      @(negedge mclk);
      case (sel)
        SIG_TXD:    v = uart_txd;
        SIG_IRQ_TX: v = irq_uart_tx;
        default:    v = irq_uart_rx;
      endcase
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Timed out waiting for %s", what);
        stop_run();
      end
    end
  endtask

  // Start bit, data LSB first, stop bit
  task automatic send_frame(input reg_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge mclk);
      uart_rxd <= frame[i];
      repeat (BIT_CYCLES - 1) @(posedge mclk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_and_registers();
    per_data_t word;
    check_equal("reset_and_registers outputs", 16'h0001,
                {13'h0, irq_uart_rx, irq_uart_tx, uart_txd});
    for (int i = 0; i < 8; i++) begin
      check_reg($sformatf("reset_and_registers offset %0d", i), reg_off_t'(i), 8'h00);
    end
    reg_write(CTRL_OFF, 8'hff);
    check_reg("reset_and_registers ctrl mask", CTRL_OFF, 8'h71);
    reg_write(BAUD_LO_OFF, 8'h5a);
    reg_write(BAUD_HI_OFF, 8'ha5);
    check_reg("reset_and_registers baud lo", BAUD_LO_OFF, 8'h5a);
    check_reg("reset_and_registers baud hi", BAUD_HI_OFF, 8'ha5);
    bus_read(BASE_WORD + 14'd1, word);
    check_equal("reset_and_registers baud word", 16'ha55a, word);
  endtask

  task automatic address_decode();
    per_data_t word;
    bus_read(BASE_WORD - 14'd1, word);
    check_equal("address_decode below", 16'h0000, word);
    bus_read(BASE_WORD + 14'd4, word);
    check_equal("address_decode above", 16'h0000, word);
    // Same low address bits as CTRL and BAUD
    bus_write(BASE_WORD + 14'd4, 2'b11, 16'h0000);
    bus_write(BASE_WORD + 14'd5, 2'b11, 16'h0000);
    check_reg("address_decode ctrl kept", CTRL_OFF, 8'h71);
    check_reg("address_decode baud lo kept", BAUD_LO_OFF, 8'h5a);
    check_reg("address_decode baud hi kept", BAUD_HI_OFF, 8'ha5);
  endtask

  task automatic transmit_frame();
    reg_byte_t  b;
    logic [9:0] frame;
    b     = random_byte();
    frame = {1'b1, b, 1'b0};
    reg_write(BAUD_LO_OFF, 8'(TEST_BAUD));
    reg_write(BAUD_HI_OFF, 8'h00);
    reg_write(CTRL_OFF, 8'h41);
    reg_write(DATA_TX_OFF, b);
    wait_level(SIG_TXD, 1'b0, "the transmit start bit");
    // Mid-bit sampling
    repeat (BIT_CYCLES / 2) @(negedge mclk);
    for (int i = 0; i < 10; i++) begin
      check_equal($sformatf("transmit_frame bit %0d", i), {15'h0, frame[i]}, {15'h0, uart_txd});
      repeat (BIT_CYCLES) @(negedge mclk);
    end
    wait_level(SIG_IRQ_TX, 1'b1, "the transmit interrupt");
    check_reg("transmit_frame status", STATUS_OFF, 8'h40);
    reg_write(STATUS_OFF, 8'h40);
    @(negedge mclk);
    check_equal("transmit_frame irq cleared", 16'h0000, {15'h0, irq_uart_tx});
    check_reg("transmit_frame status cleared", STATUS_OFF, 8'h00);
  endtask

  task automatic receive_frame();
    reg_byte_t b;
    b = random_byte();
    reg_write(CTRL_OFF, 8'h11);
    send_frame(b);
    wait_level(SIG_IRQ_RX, 1'b1, "the receive interrupt");
    check_reg("receive_frame data", DATA_RX_OFF, b);
    check_reg("receive_frame status", STATUS_OFF, 8'h10);
  endtask

  task automatic receive_overflow();
    reg_byte_t b1;
    reg_byte_t b2;
    b1 = random_byte();
    b2 = random_byte();
    reg_write(STATUS_OFF, 8'h10);
    reg_write(CTRL_OFF, 8'h21);
    send_frame(b1);
    // Plain receive flag is masked here
    @(negedge mclk);
    check_equal("receive_overflow irq after first", 16'h0000, {15'h0, irq_uart_rx});
    send_frame(b2);
    wait_level(SIG_IRQ_RX, 1'b1, "the overflow interrupt");
    check_reg("receive_overflow status", STATUS_OFF, 8'h30);
    check_reg("receive_overflow data", DATA_RX_OFF, b2);
    @(negedge mclk);
    check_equal("receive_overflow irq held", 16'h0001, {15'h0, irq_uart_rx});
    // Both flags still set with every enable off
    reg_write(CTRL_OFF, 8'h01);
    @(negedge mclk);
    check_equal("receive_overflow irq masked", 16'h0000, {15'h0, irq_uart_rx});
  endtask

  task automatic disable_aborts();
    reg_write(STATUS_OFF, 8'h30);
    reg_write(CTRL_OFF, 8'h41);
    reg_write(DATA_TX_OFF, random_byte());
    wait_level(SIG_TXD, 1'b0, "the transmit start bit");
    repeat (3 * BIT_CYCLES) @(negedge mclk);
    check_reg("disable_aborts busy", STATUS_OFF, 8'h04);
    reg_write(CTRL_OFF, 8'h40);
    // Engine drops to idle on the edge after the enable clears
    repeat (2) @(negedge mclk);
    check_equal("disable_aborts txd", 16'h0001, {15'h0, uart_txd});
    check_reg("disable_aborts idle", STATUS_OFF, 8'h00);
    // Past the point where the frame would have ended
    repeat (FRAME_CYCLES) @(negedge mclk);
    check_reg("disable_aborts no pending", STATUS_OFF, 8'h00);
    check_equal("disable_aborts irq", 16'h0000, {15'h0, irq_uart_tx});
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    mclk       = 1'b0;
    puc_rst    = 1'b1;
    per_en     = 1'b0;
    per_addr   = '0;
    per_din    = '0;
    per_we     = '0;
    uart_rxd   = 1'b1;
    lfsr_state = 32'hdbd24cbe;
    repeat (2) @(posedge mclk);
    puc_rst <= 1'b0;
    reset_and_registers();
    address_decode();
    transmit_frame();
    receive_frame();
    receive_overflow();
    disable_aborts();
    $display("all tests passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    stop_run();
  end

endmodule

//--- msp430_uart.f
src/uart_reg_pkg.sv
src/uart_line_pkg.sv
src/uart_regs.sv
src/uart_rx_filter.sv
src/uart_rx.sv
src/uart_tx.sv
src/msp430_uart.sv
verification/msp430_uart_properties.sv
verification/msp430_uart_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the serial port testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module msp430_uart_tb -Mdir obj_dir -f msp430_uart.f

status=0
./obj_dir/Vmsp430_uart_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
